// File: list.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/alu.sv
src/cmp.sv
src/exe_stage.sv
src/exe_mem_reg.sv
src/exe_unit_top.sv
test/exe_unit_checker.sv
test/exe_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module exe_unit_tb || exit 1
out=$(./obj_dir/Vexe_unit_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && echo "run ok" || { echo "run failed"; exit 1; }

// File: src/alu.sv
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module alu (
    input  rv_isa_pkg::alu_op_t  alu_op_i,
    input  logic [`RV_XLEN-1:0]  a_i,
    input  logic [`RV_XLEN-1:0]  b_i,
    output logic [`RV_XLEN-1:0]  result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];  // only low five bits count on RV32

    always_comb begin
        case (alu_op_i)
            rv_isa_pkg::alu_add: result_o = a_i + b_i;
            rv_isa_pkg::alu_sub: result_o = a_i - b_i;
            rv_isa_pkg::alu_sll: result_o = a_i << shamt;
            rv_isa_pkg::alu_srl: result_o = a_i >> shamt;
            rv_isa_pkg::alu_sra: result_o = $unsigned($signed(a_i) >>> shamt);
            rv_isa_pkg::alu_xor: result_o = a_i ^ b_i;
            rv_isa_pkg::alu_or:  result_o = a_i | b_i;
            rv_isa_pkg::alu_and: result_o = a_i & b_i;
            default:             result_o = '0;
        endcase
    end

endmodule

// File: src/cmp.sv
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module cmp (
    input  rv_isa_pkg::cmp_op_t  cmp_op_i,
    input  logic [`RV_XLEN-1:0]  a_i,
    input  logic [`RV_XLEN-1:0]  b_i,
    output logic                 taken_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmp_op_i)
            rv_isa_pkg::beq:  taken_o = eq;
            rv_isa_pkg::bne:  taken_o = !eq;
            rv_isa_pkg::blt:  taken_o = lt_s;
            rv_isa_pkg::bge:  taken_o = !lt_s;
            rv_isa_pkg::bltu: taken_o = lt_u;
            rv_isa_pkg::bgeu: taken_o = !lt_u;
            default:          taken_o = 1'b0;  // funct3 010/011 are not branches
        endcase
    end

endmodule

// File: src/exe_mem_reg.sv
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module exe_mem_reg (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  rv_pipe_pkg::exe_result_t  exe_result_i,
    output rv_pipe_pkg::exe_result_t  exe_mem_o
);

    logic [`RV_ORDER_W-1:0] min_order;  // lowest order still allowed in
    logic                   in_valid;
    logic                   stale;

    assign in_valid = exe_result_i.ctrl.rvfi.valid_commit;

    // replayed instruction after a stall, already taken once
    assign stale = in_valid && (exe_result_i.ctrl.rvfi.order_commit < min_order);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exe_mem_o <= rv_pipe_pkg::bubble_result();
            min_order <= '0;
        end else if (!stall_i) begin
            if (stale) begin
                exe_mem_o <= rv_pipe_pkg::bubble_result();
            end else begin
                exe_mem_o <= exe_result_i;
            end

            if (in_valid && !stale) begin
                min_order <= exe_result_i.ctrl.rvfi.order_commit + 1'b1;
            end
        end
    end

endmodule

// File: src/exe_stage.sv
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module exe_stage (
    input  rv_pipe_pkg::ctrl_word_t   ctrl_word_i,
    input  rv_isa_pkg::imm_t          imm_i,
    input  logic [`RV_XLEN-1:0]       exe_fwd_i,
    input  logic [`RV_XLEN-1:0]       mem_fwd_i,
    input  logic [`RV_XLEN-1:0]       wb_fwd_i,
    input  logic                      valid_i,
    output rv_pipe_pkg::exe_result_t  exe_result_o,
    output logic                      redirect_o,
    output logic [`RV_XLEN-1:0]       redirect_pc_o
);

    logic [`RV_XLEN-1:0] rs1;
    logic [`RV_XLEN-1:0] rs2;
    logic [`RV_XLEN-1:0] cmp_b;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic                cmp_out;
    logic                br_taken;

    // operand forwarding
    always_comb begin
        case (ctrl_word_i.exe.rs1_sel)
            rv_pipe_pkg::opnd_exe_fwd: rs1 = exe_fwd_i;
            rv_pipe_pkg::opnd_mem_fwd: rs1 = mem_fwd_i;
            rv_pipe_pkg::opnd_wb_fwd:  rs1 = wb_fwd_i;
            default:                   rs1 = ctrl_word_i.rvfi.rs1_data;  // regfile read
        endcase

        case (ctrl_word_i.exe.rs2_sel)
            rv_pipe_pkg::opnd_exe_fwd: rs2 = exe_fwd_i;
            rv_pipe_pkg::opnd_mem_fwd: rs2 = mem_fwd_i;
            rv_pipe_pkg::opnd_wb_fwd:  rs2 = wb_fwd_i;
            default:                   rs2 = ctrl_word_i.rvfi.rs2_data;
        endcase
    end

    always_comb begin
        cmp_b = (ctrl_word_i.exe.cmp_sel == rv_pipe_pkg::cmp_i_imm) ? imm_i.i_imm : rs2;
        alu_a = (ctrl_word_i.exe.alu_a_sel == rv_pipe_pkg::alu_a_pc) ?
                ctrl_word_i.rvfi.pc_rdata : rs1;

        case (ctrl_word_i.exe.alu_b_sel)
            rv_pipe_pkg::alu_b_i_imm: alu_b = imm_i.i_imm;
            rv_pipe_pkg::alu_b_u_imm: alu_b = imm_i.u_imm;
            rv_pipe_pkg::alu_b_b_imm: alu_b = imm_i.b_imm;  // branch target
            rv_pipe_pkg::alu_b_s_imm: alu_b = imm_i.s_imm;
            rv_pipe_pkg::alu_b_j_imm: alu_b = imm_i.j_imm;
            rv_pipe_pkg::alu_b_rs2:   alu_b = rs2;
            default:                  alu_b = '0;
        endcase
    end

    alu u_alu (
        .alu_op_i (ctrl_word_i.exe.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_out)
    );

    cmp u_cmp (
        .cmp_op_i (ctrl_word_i.exe.cmp_op),
        .a_i      (rs1),
        .b_i      (cmp_b),
        .taken_o  (cmp_out)
    );

    assign br_taken = cmp_out && (ctrl_word_i.opcode == rv_isa_pkg::op_br);

    // fetch redirect, target is pc + b_imm from the alu
    assign redirect_o    = valid_i && br_taken;
    assign redirect_pc_o = alu_out;

    // result assembly
    always_comb begin
        if (!valid_i) begin
            exe_result_o = rv_pipe_pkg::bubble_result();
        end else begin
            exe_result_o = '{ctrl: ctrl_word_i, alu_result: alu_out, br_taken: br_taken};
            exe_result_o.ctrl.rvfi.rs1_data = rs1;  // record the value actually used
            exe_result_o.ctrl.rvfi.rs2_data = rs2;
            if (br_taken) begin
                exe_result_o.ctrl.rvfi.pc_wdata = alu_out;
            end
        end
    end

endmodule

// File: src/exe_unit_top.sv
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module exe_unit_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  rv_pipe_pkg::ctrl_word_t   ctrl_word_i,
    input  rv_isa_pkg::imm_t          imm_i,
    input  logic [`RV_XLEN-1:0]       exe_fwd_i,
    input  logic [`RV_XLEN-1:0]       mem_fwd_i,
    input  logic [`RV_XLEN-1:0]       wb_fwd_i,
    input  logic                      valid_i,
    input  logic                      stall_i,
    output rv_pipe_pkg::exe_result_t  exe_mem_o,
    output logic                      redirect_o,
    output logic [`RV_XLEN-1:0]       redirect_pc_o
);

    rv_pipe_pkg::exe_result_t exe_result;  // combinational stage output

    exe_stage u_exe_stage (
        .ctrl_word_i   (ctrl_word_i),
        .imm_i         (imm_i),
        .exe_fwd_i     (exe_fwd_i),
        .mem_fwd_i     (mem_fwd_i),
        .wb_fwd_i      (wb_fwd_i),
        .valid_i       (valid_i),
        .exe_result_o  (exe_result),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    exe_mem_reg u_exe_mem_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .exe_result_i (exe_result),
        .exe_mem_o    (exe_mem_o)
    );

endmodule

// File: src/rv_exe_cfg.svh
`ifndef RV_EXE_CFG_SVH
`define RV_EXE_CFG_SVH

`define RV_XLEN 32      // RV32I data word
`define RV_ORDER_W 64   // retirement order counter
`define RV_RESET_PC 32'h4000_0000  // pc shown in bubbles

`endif

// File: src/rv_isa_pkg.sv
`include "rv_exe_cfg.svh"

package rv_isa_pkg;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // decode folds funct7[5] into sub and sra
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // branch funct3 as in the ISA
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] i_imm;
        logic [`RV_XLEN-1:0] s_imm;
        logic [`RV_XLEN-1:0] b_imm;
        logic [`RV_XLEN-1:0] u_imm;
        logic [`RV_XLEN-1:0] j_imm;
    } imm_t;  // already sign extended by decode

endpackage

// File: src/rv_pipe_pkg.sv
`include "rv_exe_cfg.svh"

package rv_pipe_pkg;

    // forwarding source, shared by rs1 and rs2
    typedef enum logic [1:0] {
        opnd_regfile = 2'b00,
        opnd_exe_fwd = 2'b01,
        opnd_mem_fwd = 2'b10,
        opnd_wb_fwd  = 2'b11
    } opnd_sel_t;

    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmp_sel_t;

    typedef enum logic {
        alu_a_rs1 = 1'b0,
        alu_a_pc  = 1'b1
    } alu_a_sel_t;

    typedef enum logic [2:0] {
        alu_b_i_imm = 3'd0,
        alu_b_u_imm = 3'd1,
        alu_b_b_imm = 3'd2,
        alu_b_s_imm = 3'd3,
        alu_b_j_imm = 3'd4,
        alu_b_rs2   = 3'd5
    } alu_b_sel_t;

    typedef struct packed {
        opnd_sel_t           rs1_sel;
        opnd_sel_t           rs2_sel;
        cmp_sel_t            cmp_sel;
        alu_a_sel_t          alu_a_sel;
        alu_b_sel_t          alu_b_sel;
        rv_isa_pkg::alu_op_t alu_op;
        rv_isa_pkg::cmp_op_t cmp_op;
    } exe_ctrl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic [2:0] funct3;  // access size and sign
    } mem_ctrl_t;

    typedef struct packed {
        logic       ld_reg;
        logic [4:0] rd;
    } wb_ctrl_t;

    // retirement record, filled in as the instruction moves down the pipe
    typedef struct packed {
        logic                   valid_commit;
        logic [`RV_ORDER_W-1:0] order_commit;
        logic [`RV_XLEN-1:0]    instruction;
        logic [4:0]             rs1_addr;
        logic [4:0]             rs2_addr;
        logic [`RV_XLEN-1:0]    rs1_data;
        logic [`RV_XLEN-1:0]    rs2_data;
        logic [`RV_XLEN-1:0]    pc_rdata;
        logic [`RV_XLEN-1:0]    pc_wdata;
        logic [`RV_XLEN-1:0]    rd_wdata;
    } rvfi_t;

    typedef struct packed {
        rv_isa_pkg::opcode_t opcode;
        exe_ctrl_t           exe;
        mem_ctrl_t           mem;
        wb_ctrl_t            wb;
        rvfi_t               rvfi;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t          ctrl;
        logic [`RV_XLEN-1:0] alu_result;
        logic                br_taken;
    } exe_result_t;

    // empty slot: no enables, nothing retires
    function automatic exe_result_t bubble_result();
        exe_result_t b;
        b = '0;
        b.ctrl.opcode = rv_isa_pkg::op_imm;  // looks like a nop
        b.ctrl.rvfi.pc_rdata = `RV_RESET_PC;
        return b;
    endfunction

endpackage

// File: test/exe_unit_checker.sv
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module exe_unit_checker (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic                     stall_i,
    input logic                     redirect_i,
    input logic [`RV_XLEN-1:0]      redirect_pc_i,
    input rv_pipe_pkg::exe_result_t exe_mem_i
);

    int fail_count = 0;  // failed assertions so far

    // a branch that steers fetch must also land in the exe/mem register
    redirect_reaches_register: assert property (@(posedge clk)
        (rst_n_i && !stall_i && redirect_i) |=>
            (exe_mem_i.br_taken && exe_mem_i.ctrl.rvfi.pc_wdata == $past(redirect_pc_i)))
    else begin
        fail_count++;
        $error("redirected branch did not reach exe_mem_o with its target");
    end

    stall_holds_register: assert property (@(posedge clk)
        (rst_n_i && stall_i) |=> $stable(exe_mem_i))
    else begin
        fail_count++;
        $error("exe_mem_o changed across a stalled edge");
    end

    reset_gives_bubble: assert property (@(posedge clk)
        !rst_n_i |=> !exe_mem_i.ctrl.rvfi.valid_commit)
    else begin
        fail_count++;
        $error("exe_mem_o shows a valid commit after a reset edge");
    end

endmodule

// File: test/exe_unit_tb.sv
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module exe_unit_tb;

    typedef struct packed {
        rv_pipe_pkg::ctrl_word_t ctrl;
        rv_isa_pkg::imm_t        imm;
        logic [`RV_XLEN-1:0]     exe_fwd;
        logic [`RV_XLEN-1:0]     mem_fwd;
        logic [`RV_XLEN-1:0]     wb_fwd;
        logic                    valid;
    } stim_t;  // everything decode and the later stages present in one cycle

    logic                     clk;
    logic                     rst_n_i;
    logic                     stall_i;
    stim_t                    stim;
    rv_pipe_pkg::exe_result_t exe_mem_o;
    logic                     redirect_o;
    logic [`RV_XLEN-1:0]      redirect_pc_o;

    rv_pipe_pkg::exe_result_t exp_q;  // expected exe/mem register contents
    logic                     model_ready;
    logic [`RV_ORDER_W-1:0]   next_order;
    int                       checks;
    int                       errors;
    int                       tests_run;
    int                       errors_at_start;

    rv_isa_pkg::opcode_t opcodes [9] = '{rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc,
        rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr, rv_isa_pkg::op_br, rv_isa_pkg::op_load,
        rv_isa_pkg::op_store, rv_isa_pkg::op_imm, rv_isa_pkg::op_reg};
    rv_isa_pkg::cmp_op_t cmp_ops [6] = '{rv_isa_pkg::beq, rv_isa_pkg::bne, rv_isa_pkg::blt,
        rv_isa_pkg::bge, rv_isa_pkg::bltu, rv_isa_pkg::bgeu};

    exe_unit_top dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ctrl_word_i   (stim.ctrl),
        .imm_i         (stim.imm),
        .exe_fwd_i     (stim.exe_fwd),
        .mem_fwd_i     (stim.mem_fwd),
        .wb_fwd_i      (stim.wb_fwd),
        .valid_i       (stim.valid),
        .stall_i       (stall_i),
        .exe_mem_o     (exe_mem_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    bind exe_unit_top exe_unit_checker u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_o),
        .redirect_pc_i (redirect_pc_o),
        .exe_mem_i     (exe_mem_o)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error: %s is 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    function automatic logic [`RV_XLEN-1:0] pick_source(input rv_pipe_pkg::opnd_sel_t sel,
                                                      input logic [`RV_XLEN-1:0] regfile,
                                                      input stim_t s);
        case (sel)
            rv_pipe_pkg::opnd_exe_fwd: return s.exe_fwd;
            rv_pipe_pkg::opnd_mem_fwd: return s.mem_fwd;
            rv_pipe_pkg::opnd_wb_fwd:  return s.wb_fwd;
            default:                   return regfile;
        endcase
    endfunction

    function automatic logic [31:0] ref_alu(input rv_isa_pkg::alu_op_t op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] fill;
        fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0;  // sign bits for sra
        case (op)
            rv_isa_pkg::alu_add: return a + b;
            rv_isa_pkg::alu_sub: return a - b;
            rv_isa_pkg::alu_sll: return a << b[4:0];
            rv_isa_pkg::alu_srl: return a >> b[4:0];
            rv_isa_pkg::alu_sra: return (a >> b[4:0]) | fill;
            rv_isa_pkg::alu_xor: return a ^ b;
            rv_isa_pkg::alu_or:  return a | b;
            default:             return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(input rv_isa_pkg::cmp_op_t op,
                                       input logic [31:0] a, input logic [31:0] b);
        logic [31:0] a_flip;
        logic [31:0] b_flip;
        a_flip = a ^ 32'h8000_0000;  // signed order becomes unsigned order
        b_flip = b ^ 32'h8000_0000;
        case (op)
            rv_isa_pkg::beq:  return a == b;
            rv_isa_pkg::bne:  return a != b;
            rv_isa_pkg::blt:  return a_flip < b_flip;
            rv_isa_pkg::bge:  return a_flip >= b_flip;
            rv_isa_pkg::bltu: return a < b;
            rv_isa_pkg::bgeu: return a >= b;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic rv_pipe_pkg::exe_result_t ref_result(input stim_t s);
        rv_pipe_pkg::exe_result_t r;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] cmp_b;
        r = '0;
        if (!s.valid) begin
            r.ctrl.opcode = rv_isa_pkg::op_imm;  // bubble looks like a nop
            r.ctrl.rvfi.pc_rdata = `RV_RESET_PC;
        end else begin
            rs1 = pick_source(s.ctrl.exe.rs1_sel, s.ctrl.rvfi.rs1_data, s);
            rs2 = pick_source(s.ctrl.exe.rs2_sel, s.ctrl.rvfi.rs2_data, s);
            op_a = (s.ctrl.exe.alu_a_sel == rv_pipe_pkg::alu_a_pc) ? s.ctrl.rvfi.pc_rdata : rs1;
            case (s.ctrl.exe.alu_b_sel)
                rv_pipe_pkg::alu_b_i_imm: op_b = s.imm.i_imm;
                rv_pipe_pkg::alu_b_u_imm: op_b = s.imm.u_imm;
                rv_pipe_pkg::alu_b_b_imm: op_b = s.imm.b_imm;
                rv_pipe_pkg::alu_b_s_imm: op_b = s.imm.s_imm;
                rv_pipe_pkg::alu_b_j_imm: op_b = s.imm.j_imm;
                default:                  op_b = rs2;
            endcase
            cmp_b = (s.ctrl.exe.cmp_sel == rv_pipe_pkg::cmp_i_imm) ? s.imm.i_imm : rs2;
            r.ctrl = s.ctrl;
            r.ctrl.rvfi.rs1_data = rs1;
            r.ctrl.rvfi.rs2_data = rs2;
            r.alu_result = ref_alu(s.ctrl.exe.alu_op, op_a, op_b);
            r.br_taken = (s.ctrl.opcode == rv_isa_pkg::op_br) &&
                         ref_taken(s.ctrl.exe.cmp_op, rs1, cmp_b);
            if (r.br_taken) begin
                r.ctrl.rvfi.pc_wdata = r.alu_result;  // pc + b_imm
            end
        end
        return r;
    endfunction

    function automatic stim_t random_stim();
        stim_t s;
        s.ctrl.opcode = opcodes[4'($urandom_range(0, 8))];
        s.ctrl.exe.rs1_sel = rv_pipe_pkg::opnd_sel_t'(2'($urandom_range(0, 3)));
        s.ctrl.exe.rs2_sel = rv_pipe_pkg::opnd_sel_t'(2'($urandom_range(0, 3)));
        s.ctrl.exe.cmp_sel = rv_pipe_pkg::cmp_sel_t'(1'($urandom_range(0, 1)));
        s.ctrl.exe.alu_a_sel = rv_pipe_pkg::alu_a_sel_t'(1'($urandom_range(0, 1)));
        s.ctrl.exe.alu_b_sel = rv_pipe_pkg::alu_b_sel_t'(3'($urandom_range(0, 5)));
        s.ctrl.exe.alu_op = rv_isa_pkg::alu_op_t'(3'($urandom_range(0, 7)));
        s.ctrl.exe.cmp_op = cmp_ops[3'($urandom_range(0, 5))];
        s.ctrl.mem = 5'($urandom);
        s.ctrl.wb = 6'($urandom);
        s.ctrl.rvfi.valid_commit = 1'b1;
        s.ctrl.rvfi.order_commit = '0;  // filled in when driven
        s.ctrl.rvfi.instruction = $urandom;
        s.ctrl.rvfi.rs1_addr = 5'($urandom);
        s.ctrl.rvfi.rs2_addr = 5'($urandom);
        s.ctrl.rvfi.rs1_data = $urandom;
        s.ctrl.rvfi.rs2_data = $urandom;
        s.ctrl.rvfi.pc_rdata = $urandom & 32'hffff_fffc;
        s.ctrl.rvfi.pc_wdata = s.ctrl.rvfi.pc_rdata + 32'd4;
        s.ctrl.rvfi.rd_wdata = $urandom;
        s.imm = {$urandom, $urandom, $urandom, $urandom, $urandom};
        s.exe_fwd = $urandom;
        s.mem_fwd = $urandom;
        s.wb_fwd = $urandom;
        s.valid = 1'b1;
        return s;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;  // inputs change shortly after the edge
    endtask

    task automatic drive_cycle(input stim_t s, input logic stall);
        stim_t t;
        t = s;
        if (t.valid) begin
            t.ctrl.rvfi.order_commit = next_order;
            next_order = next_order + 1'b1;
        end
        stim = t;
        stall_i = stall;
        next_cycle();
    endtask

    // 1 ns before each edge, check the redirect and predict the register
    task automatic predict_cycle();
        rv_pipe_pkg::exe_result_t now;
        stim_t idle;
        logic exp_redirect;
        idle = '0;
        now = ref_result(stim);
        exp_redirect = stim.valid && now.br_taken;
        check_value("redirect_o", 512'(redirect_o), 512'(exp_redirect));
        if (exp_redirect) begin
            check_value("redirect_pc_o", 512'(redirect_pc_o), 512'(now.alu_result));
        end
        if (!rst_n_i) begin
            exp_q = ref_result(idle);
        end else if (!stall_i) begin
            exp_q = now;
        end
        model_ready = 1'b1;
    endtask

    always @(posedge clk) begin
        #1;
        if (model_ready) begin
            check_value("exe_mem_o.alu_result", 512'(exe_mem_o.alu_result), 512'(exp_q.alu_result));
            check_value("exe_mem_o", 512'(exe_mem_o), 512'(exp_q));
        end
        #18;
        predict_cycle();
    end

    task automatic check_bubble();
        check_value("exe_mem_o.valid_commit", 512'(exe_mem_o.ctrl.rvfi.valid_commit), 512'(0));
        check_value("exe_mem_o.order_commit", 512'(exe_mem_o.ctrl.rvfi.order_commit), 512'(0));
        check_value("exe_mem_o.mem_read", 512'(exe_mem_o.ctrl.mem.mem_read), 512'(0));
        check_value("exe_mem_o.mem_write", 512'(exe_mem_o.ctrl.mem.mem_write), 512'(0));
        check_value("exe_mem_o.ld_reg", 512'(exe_mem_o.ctrl.wb.ld_reg), 512'(0));
        check_value("exe_mem_o.pc_rdata", 512'(exe_mem_o.ctrl.rvfi.pc_rdata), 512'(`RV_RESET_PC));
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %-14s finished, %0d errors", name, errors - errors_at_start);
    endtask

    task automatic test_alu_ops();
        stim_t s;
        begin_test();
        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < 4; k++) begin
                s = random_stim();
                s.ctrl.opcode = (k % 2 == 0) ? rv_isa_pkg::op_reg : rv_isa_pkg::op_imm;
                s.ctrl.exe.rs1_sel = rv_pipe_pkg::opnd_regfile;
                s.ctrl.exe.rs2_sel = rv_pipe_pkg::opnd_regfile;
                s.ctrl.exe.alu_a_sel = rv_pipe_pkg::alu_a_rs1;
                s.ctrl.exe.alu_b_sel = (k % 2 == 0) ? rv_pipe_pkg::alu_b_rs2
                                                    : rv_pipe_pkg::alu_b_i_imm;
                s.ctrl.exe.alu_op = rv_isa_pkg::alu_op_t'(3'(op));
                drive_cycle(s, 1'b0);
            end
        end
        end_test("alu_ops");
    endtask

    task automatic test_forwarding();
        stim_t s;
        begin_test();
        for (int k = 0; k < 24; k++) begin
            s = random_stim();  // rs1 and rs2 selects stay random
            s.ctrl.opcode = rv_isa_pkg::op_reg;
            s.ctrl.exe.alu_a_sel = rv_pipe_pkg::alu_a_rs1;
            s.ctrl.exe.alu_b_sel = rv_pipe_pkg::alu_b_rs2;
            drive_cycle(s, 1'b0);
        end
        end_test("forwarding");
    endtask

    task automatic test_pc_imm();
        stim_t s;
        rv_pipe_pkg::alu_b_sel_t b_sel;
        begin_test();
        for (int k = 0; k < 20; k++) begin
            s = random_stim();
            b_sel = rv_pipe_pkg::alu_b_sel_t'(3'(k % 5));  // i, u, b, s and j in turn
            s.ctrl.exe.alu_b_sel = b_sel;
            s.ctrl.exe.alu_op = rv_isa_pkg::alu_add;
            case (b_sel)
                rv_pipe_pkg::alu_b_u_imm: s.ctrl.opcode = rv_isa_pkg::op_auipc;
                rv_pipe_pkg::alu_b_j_imm: s.ctrl.opcode = rv_isa_pkg::op_jal;
                rv_pipe_pkg::alu_b_s_imm: s.ctrl.opcode = rv_isa_pkg::op_store;
                rv_pipe_pkg::alu_b_b_imm: s.ctrl.opcode = rv_isa_pkg::op_auipc;
                default:                  s.ctrl.opcode = rv_isa_pkg::op_jalr;
            endcase
            s.ctrl.exe.alu_a_sel = (b_sel == rv_pipe_pkg::alu_b_i_imm ||
                                    b_sel == rv_pipe_pkg::alu_b_s_imm) ?
                                   rv_pipe_pkg::alu_a_rs1 : rv_pipe_pkg::alu_a_pc;
            drive_cycle(s, 1'b0);
        end
        end_test("pc_imm");
    endtask

    task automatic test_branches();
        stim_t s;
        begin_test();
        for (int k = 0; k < 42; k++) begin
            s = random_stim();
            s.ctrl.opcode = (k < 36) ? rv_isa_pkg::op_br : rv_isa_pkg::op_jal;
            s.ctrl.exe.rs1_sel = rv_pipe_pkg::opnd_regfile;
            s.ctrl.exe.rs2_sel = rv_pipe_pkg::opnd_regfile;
            s.ctrl.exe.cmp_sel = rv_pipe_pkg::cmp_sel_t'(1'(k % 2));
            s.ctrl.exe.cmp_op = cmp_ops[3'((k / 2) % 6)];
            s.ctrl.exe.alu_a_sel = rv_pipe_pkg::alu_a_pc;
            s.ctrl.exe.alu_b_sel = rv_pipe_pkg::alu_b_b_imm;
            s.ctrl.exe.alu_op = rv_isa_pkg::alu_add;
            if (k % 3 == 0) begin  // equal operands
                s.ctrl.rvfi.rs1_data = (k % 2 == 1) ? s.imm.i_imm : s.ctrl.rvfi.rs2_data;
            end
            drive_cycle(s, 1'b0);
        end
        end_test("branches");
    endtask

    task automatic test_bubbles_reset();
        stim_t s;
        begin_test();
        s = random_stim();
        s.valid = 1'b0;
        repeat (4) drive_cycle(s, 1'b0);
        check_bubble();
        rst_n_i = 1'b0;
        drive_cycle(random_stim(), 1'b0);
        check_bubble();
        drive_cycle(random_stim(), 1'b0);
        check_bubble();
        rst_n_i = 1'b1;
        repeat (4) drive_cycle(random_stim(), 1'b0);
        end_test("bubbles_reset");
    endtask

    task automatic test_stall();
        rv_pipe_pkg::exe_result_t held;
        logic [`RV_ORDER_W-1:0] want;
        int n;
        begin_test();
        for (int round = 0; round < 3; round++) begin
            drive_cycle(random_stim(), 1'b0);
            held = exp_q;  // predicted contents after the last load
            want = next_order;
            drive_cycle(random_stim(), 1'b1);
            repeat (3) begin
                check_value("exe_mem_o", 512'(exe_mem_o), 512'(held));
                next_cycle();  // inputs stay steady
            end
            stall_i = 1'b0;
            n = 0;
            while (!(exe_mem_o.ctrl.rvfi.valid_commit &&
                     exe_mem_o.ctrl.rvfi.order_commit == want) && n < 8) begin
                next_cycle();
                n++;
            end
            if (n >= 8) begin
                errors++;
                $display("timeout: the stalled instruction never reached exe_mem_o");
            end
        end
        end_test("stall");
    endtask

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        stim = '0;
        exp_q = '0;
        model_ready = 1'b0;
        next_order = 1;
        checks = 0;
        errors = 0;
        tests_run = 0;
        errors_at_start = 0;
        void'($urandom(89890));
        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        test_alu_ops();
        test_forwarding();
        test_pc_imm();
        test_branches();
        test_bubbles_reset();
        test_stall();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, checks, errors, dut.u_checker.fail_count);
        if (errors == 0 && dut.u_checker.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
